// ==== src/cpuSettings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath width for registers, ALU and addresses
`define XLEN 32

// Memory depths in 32-bit words
`define IMEM_WORDS 64   // Program store
`define DMEM_WORDS 64   // Load/store space

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== src/isaPkg.sv ====
`include "cpuSettings.svh"

package isaPkg;

    typedef logic [`XLEN-1:0] wordT;    // Data word or byte address
    typedef logic [31:0]      instT;    // Raw instruction word
    typedef logic [4:0]       regIdxT;  // x0 .. x31
    typedef logic [2:0]       funct3T;

    // Word index into the program store
    typedef logic [$clog2(`IMEM_WORDS)-1:0] imemIdxT;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,  // add sub and or slt
        opImm    = 7'b0010011,  // addi
        opLoad   = 7'b0000011,  // lw
        opStore  = 7'b0100011,  // sw
        opBranch = 7'b1100011   // beq
    } opcodeE;

    // funct3 codes the decoder cares about
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;
    localparam funct3T f3Word   = 3'b010;   // lw and sw
    localparam funct3T f3Beq    = 3'b000;

endpackage

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    import isaPkg::*;

    // Operations the ALU knows
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    // Main control bits for one instruction
    typedef struct packed {
        logic  regWrite;
        logic  aluSrcImm;   // Second operand from immediate
        logic  memWrite;
        logic  memToReg;    // Write back load data
        logic  branch;
        aluOpE aluOp;
    } ctrlT;

    // Everything later stages need from the instruction word
    typedef struct packed {
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        wordT   imm;        // Sign-extended, format picked by opcode
        ctrlT   ctrl;
    } decodedT;

endpackage

// ==== src/instFetch.sv ====
`include "cpuSettings.svh"

module instFetch
    import isaPkg::*;
(
    input  logic    CLK,
    input  logic    rstN,
    input  logic    run,
    input  logic    takeBranch,
    input  wordT    branchTarget,
    input  logic    progWe,
    input  imemIdxT progAddr,
    input  instT    progData,
    output wordT    pc,
    output instT    inst
);

    instT    imem [`IMEM_WORDS];    // Program store
    wordT    pcPlus4;
    wordT    nextPc;
    imemIdxT fetchIdx;

    assign pcPlus4 = pc + wordT'(4);
    assign nextPc  = takeBranch ? branchTarget : pcPlus4;

    // Byte offset bits dropped
    assign fetchIdx = pc[$bits(imemIdxT)+1:2];

    // PC only advances while running
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= wordT'(`RESET_PC);
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // Load port from the testbench
    always_ff @(posedge CLK) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    assign inst = imem[fetchIdx];   // Asynchronous fetch

endmodule

// ==== src/decodeUnit.sv ====
module decodeUnit
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  instT    inst,
    output decodedT dec
);

    opcodeE opcode;
    funct3T funct3;
    logic   subSel;     // Bit 30 only counts for R-type
    wordT   immI;
    wordT   immS;
    wordT   immB;
    wordT   imm;
    ctrlT   ctrl;
    aluOpE  f3AluOp;
    logic   f3AluOk;

    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign subSel = inst[30] && (opcode == opReg);

    // Immediate formats, all sign-extended from bit 31
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // ALU control from funct3
    always_comb begin
        f3AluOk = 1'b1;
        case (funct3)
            f3AddSub: f3AluOp = subSel ? aluSub : aluAdd;
            f3Slt:    f3AluOp = aluSlt;
            f3Or:     f3AluOp = aluOr;
            f3And:    f3AluOp = aluAnd;
            default: begin
                f3AluOp = aluAdd;
                f3AluOk = 1'b0;  // Unsupported op suppresses write back
            end
        endcase
    end

    // Main control
    always_comb begin
        ctrl = '0;      // Unknown opcodes become no-ops
        imm  = immI;
        case (opcode)
            opReg: begin
                ctrl.regWrite = f3AluOk;
                ctrl.aluOp    = f3AluOp;
            end
            opImm: begin
                ctrl.regWrite  = f3AluOk;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = f3AluOp;
            end
            opLoad: begin
                ctrl.regWrite  = (funct3 == f3Word);
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opStore: begin
                ctrl.memWrite  = (funct3 == f3Word);
                ctrl.aluSrcImm = 1'b1;
                imm            = immS;
            end
            opBranch: begin
                ctrl.branch = (funct3 == f3Beq);
                ctrl.aluOp  = aluSub;    // Compare by difference
                imm         = immB;
            end
            default: ctrl = '0;
        endcase
    end

    assign dec = '{rs1: inst[19:15], rs2: inst[24:20], rd: inst[11:7], imm: imm, ctrl: ctrl};

endmodule

// ==== src/regFile.sv ====
module regFile
    import isaPkg::*;
(
    input  logic   CLK,
    input  logic   rstN,
    input  logic   we,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  wordT   wd,
    output wordT   rd1,
    output wordT   rd2
);

    wordT regs [32];

    // x0 never written so it reads zero forever
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    // Combinational read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

// ==== src/execUnit.sv ====
module execUnit
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  decodedT dec,
    input  wordT    pc,
    input  wordT    rd1,
    input  wordT    rd2,
    output wordT    aluResult,
    output logic    takeBranch,
    output wordT    branchTarget
);

    wordT opB;
    wordT diff;
    logic lessThan;

    assign opB      = dec.ctrl.aluSrcImm ? dec.imm : rd2;
    assign diff     = rd1 - opB;
    assign lessThan = $signed(rd1) < $signed(opB);   // Signed compare for slt

    always_comb begin
        case (dec.ctrl.aluOp)
            aluAdd:  aluResult = rd1 + opB;
            aluSub:  aluResult = diff;
            aluAnd:  aluResult = rd1 & opB;
            aluOr:   aluResult = rd1 | opB;
            aluSlt:  aluResult = wordT'(lessThan);
            default: aluResult = rd1 + opB;
        endcase
    end

    // beq taken on equal operands
    assign takeBranch   = dec.ctrl.branch && (diff == '0);
    assign branchTarget = pc + dec.imm;  // B-type offset already has bit 0 clear

endmodule

// ==== src/dataMem.sv ====
`include "cpuSettings.svh"

module dataMem
    import isaPkg::*;
(
    input  logic CLK,
    input  logic we,
    input  wordT addr,
    input  wordT wd,
    output wordT rdata
);

    localparam int IdxBits = $clog2(`DMEM_WORDS);

    wordT               mem [`DMEM_WORDS];
    logic [IdxBits-1:0] wordIdx;

    // Word aligned, low two bits ignored
    assign wordIdx = addr[IdxBits+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wd;
        end
    end

    assign rdata = mem[wordIdx];   // Read in the same cycle

endmodule

// ==== src/singleCpu.sv ====
module singleCpu
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic    CLK,
    input  logic    rstN,
    input  logic    run,
    input  logic    progWe,
    input  imemIdxT progAddr,
    input  instT    progData,
    output wordT    pc,
    output instT    out,
    output logic    storeValid,
    output wordT    storeAddr,
    output wordT    storeData
);

    instT    inst;
    decodedT dec;
    wordT    rd1;
    wordT    rd2;
    wordT    aluResult;
    wordT    memRdata;
    wordT    writeBack;
    wordT    branchTarget;
    logic    takeBranch;
    logic    regWe;
    logic    memWe;

    // Nothing is written while halted
    assign regWe = run && dec.ctrl.regWrite;
    assign memWe = run && dec.ctrl.memWrite;

    assign writeBack = dec.ctrl.memToReg ? memRdata : aluResult;

    instFetch i_instFetch (
        .CLK(CLK), .rstN(rstN), .run(run),
        .takeBranch(takeBranch), .branchTarget(branchTarget),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .inst(inst)
    );

    decodeUnit i_decodeUnit (.inst(inst), .dec(dec));

    regFile i_regFile (
        .CLK(CLK), .rstN(rstN), .we(regWe),
        .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd), .wd(writeBack),
        .rd1(rd1), .rd2(rd2)
    );

    execUnit i_execUnit (
        .dec(dec), .pc(pc), .rd1(rd1), .rd2(rd2),
        .aluResult(aluResult), .takeBranch(takeBranch), .branchTarget(branchTarget)
    );

    dataMem i_dataMem (.CLK(CLK), .we(memWe), .addr(aluResult), .wd(rd2), .rdata(memRdata));

    assign out = inst;      // Instruction echo

    // Store bus mirrors the data memory write
    assign storeValid = memWe;
    assign storeAddr  = aluResult;
    assign storeData  = rd2;

endmodule

// ==== testbench/cpuTests.svh ====
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// First word would store if it ever ran
task automatic testReset();
    startTest("testReset");
    addInst(encSw(5'd0, 5'd0, 12'h010));
    addInst(encAddi(5'd1, 5'd0, 12'h123));
    loadProgram();
    applyReset();
    repeat (4) begin
        @(negedge CLK);
        checkWord("pc", `RESET_PC, pc);
        checkWord("out", prog[0], out);
        checkTrue(!storeValid, "store strobe went high while run was low");
    end
endtask

task automatic testAluOps();
    wordT a;
    wordT b;
    startTest("testAluOps");
    a = 32'hFFFF_FFF9;  // -7
    b = 32'h0000_006C;
    addInst(encAddi(5'd1, 5'd0, 12'hFF9));
    addInst(encAddi(5'd2, 5'd0, 12'h06C));
    addInst(encAddi(5'd9, 5'd0, 12'hF9C));              // -100
    addInst(encR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));     // add
    addInst(encSw(5'd3, 5'd0, 12'h040));
    addInst(encR(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));     // sub
    addInst(encSw(5'd4, 5'd0, 12'h044));
    addInst(encR(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));     // and
    addInst(encSw(5'd5, 5'd0, 12'h048));
    addInst(encR(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));     // or
    addInst(encSw(5'd6, 5'd0, 12'h04C));
    addInst(encR(7'h00, 3'b010, 5'd7, 5'd1, 5'd2));     // slt
    addInst(encSw(5'd7, 5'd0, 12'h050));
    addInst(encR(7'h00, 3'b010, 5'd8, 5'd2, 5'd1));
    addInst(encSw(5'd8, 5'd0, 12'h054));
    addInst(encR(7'h00, 3'b010, 5'd10, 5'd9, 5'd1));    // Both negative
    addInst(encSw(5'd10, 5'd0, 12'h058));
    expectStore(32'h40, a + b);
    expectStore(32'h44, a - b);
    expectStore(32'h48, a & b);
    expectStore(32'h4C, a | b);
    expectStore(32'h50, 32'd1);     // -7 < 108
    expectStore(32'h54, 32'd0);     // 108 < -7 is false
    expectStore(32'h58, 32'd1);     // -100 < -7
    loadAndRun();
endtask

task automatic testLoadStore();
    wordT v1;
    wordT v2;
    startTest("testLoadStore");
    v1 = 32'h0000_07AB;
    v2 = 32'hFFFF_F8CD;   // Sign-extended 12'h8CD
    addInst(encAddi(5'd1, 5'd0, 12'h7AB));
    addInst(encAddi(5'd2, 5'd0, 12'h8CD));
    addInst(encAddi(5'd10, 5'd0, 12'h080));     // Base address
    addInst(encSw(5'd1, 5'd10, 12'h000));
    addInst(encSw(5'd2, 5'd10, 12'h004));
    addInst(encLw(5'd3, 5'd10, 12'h000));
    addInst(encLw(5'd4, 5'd10, 12'h004));
    addInst(encSw(5'd3, 5'd10, 12'h008));
    addInst(encSw(5'd4, 5'd10, 12'hFFC));       // Negative offset
    expectStore(32'h80, v1);
    expectStore(32'h84, v2);
    expectStore(32'h88, v1);
    expectStore(32'h7C, v2);
    loadAndRun();
endtask

task automatic testBranch();
    wordT wantPc [7];
    startTest("testBranch");
    addInst(encAddi(5'd1, 5'd0, 12'h005));
    addInst(encAddi(5'd2, 5'd0, 12'h005));
    addInst(encAddi(5'd3, 5'd0, 12'h009));
    addInst(encBeq(5'd1, 5'd2, 13'd8));     // Equal operands so PC 12 jumps to 20
    addInst(encSw(5'd1, 5'd0, 12'h020));    // Skipped
    addInst(encBeq(5'd1, 5'd3, 13'd8));     // Unequal operands fall through
    addInst(encSw(5'd3, 5'd0, 12'h024));
    addInst(encSw(5'd2, 5'd0, 12'h028));
    expectStore(32'h24, 32'd9);
    expectStore(32'h28, 32'd5);
    wantPc = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd12 + 32'd8, 32'd24, 32'd28};
    loadAndRun();
    checkTrue(pcTrace.size() == $size(wantPc), "PC trace length does not match the branch rule");
    foreach (wantPc[i]) begin
        if (i < pcTrace.size()) begin
            checkWord("pc", wantPc[i], pcTrace[i]);
        end
    end
endtask

task automatic testZeroReg();
    startTest("testZeroReg");
    addInst(encAddi(5'd0, 5'd0, 12'h055));
    addInst(encAddi(5'd1, 5'd0, 12'h055));
    addInst(encSw(5'd0, 5'd0, 12'h030));
    addInst(encR(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));     // add into x0
    addInst(encSw(5'd0, 5'd0, 12'h034));
    addInst(encSw(5'd1, 5'd0, 12'h038));
    expectStore(32'h30, '0);
    expectStore(32'h34, '0);
    expectStore(32'h38, 32'h55);
    loadAndRun();
endtask

// Register values modeled alongside the program
task automatic testRandomAddi();
    wordT        model [32];
    regIdxT      rd;
    regIdxT      rs1;
    regIdxT      rs2;
    logic [11:0] imm;
    startTest("testRandomAddi");
    foreach (model[i]) begin
        model[i] = '0;
    end
    for (int k = 0; k < 8; k++) begin
        rd  = pickReg();
        rs1 = pickReg();
        imm = 12'(randomBits(12));
        addInst(encAddi(rd, rs1, imm));
        model[rd] = model[rs1] + {{20{imm[11]}}, imm};
        addInst(encSw(rd, 5'd0, 12'(k * 8)));
        expectStore(wordT'(k * 8), model[rd]);
        rd  = pickReg();
        rs1 = pickReg();
        rs2 = pickReg();
        addInst(encR(7'h00, 3'b000, rd, rs1, rs2));
        model[rd] = model[rs1] + model[rs2];
        addInst(encSw(rd, 5'd0, 12'(k * 8 + 4)));
        expectStore(wordT'(k * 8 + 4), model[rd]);
    end
    loadAndRun();
endtask

`endif

// ==== testbench/cpuTb.sv ====
`include "cpuSettings.svh"

module cpuTb
    import isaPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MaxCycles = 2000;   // Six tests of 64 load and up to 40 run cycles with margin

    typedef struct packed {
        wordT addr;
        wordT data;
    } storeT;

    logic    CLK;
    logic    rstN;
    logic    run;
    logic    progWe;
    imemIdxT progAddr;
    instT    progData;
    wordT    pc;
    instT    out;
    logic    storeValid;
    wordT    storeAddr;
    wordT    storeData;

    instT        prog [$];      // Program of the current test
    storeT       expQ [$];      // Stores still to come in program order
    wordT        pcTrace [$];   // PC seen in each executed cycle
    string       testName;
    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lfsrState;

    singleCpu i_singleCpu (
        .CLK(CLK), .rstN(rstN), .run(run),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .out(out),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < MaxCycles) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: simulation stopped after %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    end

    // Galois LFSR stepped once per bit drawn
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic regIdxT pickReg();   // x1 .. x31
        regIdxT idx;
        idx = '0;
        while (idx == '0) begin
            idx = regIdxT'(randomBits(5));
        end
        return idx;
    endfunction

    // Instruction encoders
    function automatic instT encR(logic [6:0] funct7, funct3T funct3, regIdxT rd,
                                  regIdxT rs1, regIdxT rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic instT encAddi(regIdxT rd, regIdxT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic instT encLw(regIdxT rd, regIdxT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic instT encSw(regIdxT rs2, regIdxT rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instT encBeq(regIdxT rs1, regIdxT rs2, logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11], 7'b1100011};
    endfunction

    task automatic startTest(string name);
        testName = name;
        prog.delete();
        expQ.delete();
        $display("Running %s", name);
    endtask

    task automatic addInst(instT inst);
        prog.push_back(inst);
    endtask

    task automatic expectStore(wordT addr, wordT data);
        expQ.push_back('{addr: addr, data: data});
    endtask

    task automatic checkWord(string what, wordT expected, wordT actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkTrue(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", testName, what);
        end
    endtask

    task automatic applyReset();
        @(posedge CLK);
        rstN <= 1'b0;
        run  <= 1'b0;
        repeat (2) @(posedge CLK);
        rstN <= 1'b1;
    endtask

    // Writes the whole program store and pads it with nops tagged by index
    task automatic loadProgram();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge CLK);
            run      <= 1'b0;
            progWe   <= 1'b1;
            progAddr <= imemIdxT'(i);
            progData <= (i < prog.size()) ? prog[i] : encAddi(5'd0, 5'd0, 12'(i));
        end
        @(posedge CLK);
        progWe <= 1'b0;
    endtask

    task automatic checkStore();
        storeT want;
        if (storeValid) begin
            checkTrue(expQ.size() > 0, $sformatf("unexpected store to address %h", storeAddr));
            if (expQ.size() > 0) begin
                want = expQ.pop_front();
                checkWord("store address", want.addr, storeAddr);
                checkWord("store data", want.data, storeData);
            end
        end
    endtask

    // Runs until the PC leaves the end of the program
    task automatic runProgram();
        wordT endPc;
        endPc = wordT'(prog.size() * 4);
        pcTrace.delete();
        @(posedge CLK);
        run <= 1'b1;
        @(negedge CLK);
        while (pc != endPc) begin
            pcTrace.push_back(pc);
            checkStore();
            @(negedge CLK);
        end
        @(posedge CLK);
        run <= 1'b0;
        checkTrue(expQ.size() == 0, $sformatf("%0d expected stores never appeared", expQ.size()));
    endtask

    task automatic loadAndRun();
        applyReset();
        loadProgram();
        runProgram();
    endtask

    `include "cpuTests.svh"

    initial begin
        rstN      = 1'b0;
        run       = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        errors    = 0;
        checks    = 0;
        lfsrState = 32'h62dd;
        applyReset();
        testReset();
        testAluOps();
        testLoadStore();
        testBranch();
        testZeroReg();
        testRandomAddi();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
+incdir+testbench
src/isaPkg.sv
src/ctrlPkg.sv
src/instFetch.sv
src/decodeUnit.sv
src/regFile.sv
src/execUnit.sv
src/dataMem.sv
src/singleCpu.sv
testbench/cpuTb.sv
